// File: include/gmii_rx_defs.svh
// widths, frame limits and the apb register map of the gmii receive path, include where needed
`ifndef GMII_RX_DEFS_SVH
`define GMII_RX_DEFS_SVH

// gmii byte lane width
`define GMII_DW 8

// smallest legal frame in bytes, fcs included
// anything shorter is reported as a runt
`define MIN_FRAME_LEN 64

// crc register left over after running a good frame and its fcs
// reflected crc-32, no final inversion
`define FCS_RESIDUE 32'hDEBB_20E3

// apb byte offsets
`define REG_FRAMES_OK 8'h00
`define REG_CRC_BAD 8'h04
`define REG_FRAME_ERR 8'h08
`define REG_BYTES_OK 8'h0C
// bit 0 enables the framer
`define REG_CTRL 8'h10
// any write zeroes the statistics
`define REG_CLEAR 8'h14

`endif

// File: design/gmii_rx_pkg.sv
// shared bus, beat, status and apb word types of the gmii receive path, referenced by scoped names
`include "gmii_rx_defs.svh"

package gmii_rx_pkg;

    // one sample of the phy receive pins
    typedef struct packed {
        logic [`GMII_DW-1:0] d;
        logic                dv;
        logic                er;
    } gmii_bus_t;

    // one frame byte after preamble stripping
    typedef struct packed {
        logic [`GMII_DW-1:0] data;
        logic                valid;
        // final byte of the frame, fcs included
        logic                last;
    } rx_beat_t;

    // end of frame summary, only meaningful alongside the last beat
    typedef struct packed {
        logic valid;
        // fcs residue mismatch
        logic crc_bad;
        // er seen somewhere inside the frame
        logic gmii_err;
        // shorter than the minimum frame length
        logic runt;
    } rx_status_t;

    // apb read and write data
    typedef logic [31:0] apb_word_t;

endpackage

// File: design/ssio_sdr_in.sv
// source synchronous sdr input stage, registers the pin vector on the receive clock and forwards that clock
`timescale 1ns/100ps

module ssio_sdr_in #(
    // number of pins captured
    parameter int WIDTH = 1
) (
    input  logic             input_clk,
    input  logic [WIDTH-1:0] input_d,
    output logic             output_clk,
    output logic [WIDTH-1:0] output_q,
    input  logic             rst_n
);

    // clock seen by the capture flops
    logic clk_io;

    // capture flops, meant to land in the pad registers
    (* IOB = "TRUE" *)
    logic [WIDTH-1:0] q_reg;

    // generic path, receive clock drives the pad flops directly
    assign clk_io = input_clk;

    // same clock handed on to the logic behind this stage
    assign output_clk = input_clk;

    assign output_q = q_reg;

    // single sample per rising edge
    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            q_reg <= '0;
        end else begin
            q_reg <= input_d;
        end
    end

endmodule

// File: design/gmii_rx_framer.sv
// gmii receive framer, strips preamble and sfd and emits frame bytes with last and end of frame status
`timescale 1ns/100ps
`include "gmii_rx_defs.svh"

module gmii_rx_framer (
    input  logic                    clk_io,
    input  logic                    rst_n,
    input  logic                    enable,
    input  gmii_rx_pkg::gmii_bus_t  gmii,
    output gmii_rx_pkg::rx_beat_t   beat,
    output gmii_rx_pkg::rx_status_t status
);

    // fsm encoding
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_PREAMBLE = 2'd1;
    localparam logic [1:0] ST_DATA     = 2'd2;
    localparam logic [1:0] ST_DISCARD  = 2'd3;

    localparam logic [`GMII_DW-1:0] PRE_BYTE = `GMII_DW'('h55);
    localparam logic [`GMII_DW-1:0] SFD_BYTE = `GMII_DW'('hD5);

    // length only needs to reach the runt limit
    localparam int LEN_W = $clog2(`MIN_FRAME_LEN + 1);
    localparam logic [LEN_W-1:0] MIN_LEN = LEN_W'(`MIN_FRAME_LEN);

    logic [1:0]          state_q;
    // one byte held back until we know whether it is the last
    logic [`GMII_DW-1:0] hold_data;
    logic                hold_valid;
    logic [LEN_W-1:0]    len_q;
    logic                err_q;

    // output stage
    logic [`GMII_DW-1:0]     data_q;
    logic                    valid_q;
    logic                    last_q;
    gmii_rx_pkg::rx_status_t status_q;

    assign beat.data  = data_q;
    assign beat.valid = valid_q;
    assign beat.last  = last_q;
    assign status     = status_q;

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            hold_valid <= 1'b0;
            len_q      <= '0;
            err_q      <= 1'b0;
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            status_q   <= '0;
        end else begin
            // output flags are single cycle pulses
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            status_q <= '0;

            case (state_q)
                ST_IDLE: begin
                    hold_valid <= 1'b0;
                    len_q      <= '0;
                    err_q      <= gmii.dv & gmii.er;
                    // dv high here is always a fresh rise, every frame leaves idle until dv drops
                    if (gmii.dv) begin
                        if (!enable) begin
                            state_q <= ST_DISCARD;
                        end else if (gmii.d == PRE_BYTE) begin
                            state_q <= ST_PREAMBLE;
                        end else if (gmii.d == SFD_BYTE) begin
                            state_q <= ST_DATA;
                        end else begin
                            state_q <= ST_DISCARD;
                        end
                    end
                end

                ST_PREAMBLE: begin
                    if (!gmii.dv) begin
                        // frame ended inside the preamble, drop it
                        state_q <= ST_IDLE;
                    end else begin
                        err_q <= err_q | gmii.er;
                        if (gmii.d == SFD_BYTE) begin
                            state_q <= ST_DATA;
                        end else if (gmii.d != PRE_BYTE) begin
                            state_q <= ST_DISCARD;
                        end
                    end
                end

                ST_DATA: begin
                    if (gmii.dv) begin
                        err_q      <= err_q | gmii.er;
                        hold_valid <= 1'b1;
                        // saturate at the runt limit
                        if (len_q != MIN_LEN) begin
                            len_q <= len_q + 1'b1;
                        end
                        // previous byte is now known not to be the last
                        valid_q <= hold_valid;
                    end else begin
                        state_q    <= ST_IDLE;
                        hold_valid <= 1'b0;
                        // flush the held byte with last and the frame summary
                        if (hold_valid) begin
                            valid_q           <= 1'b1;
                            last_q            <= 1'b1;
                            status_q.valid    <= 1'b1;
                            status_q.gmii_err <= err_q;
                            status_q.runt     <= (len_q < MIN_LEN);
                        end
                    end
                end

                default: begin
                    // bad delimiter or framer disabled at the start, wait for the gap
                    if (!gmii.dv) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // byte path, qualified by the flags above
    always_ff @(posedge clk_io) begin
        if (gmii.dv && state_q == ST_DATA) begin
            hold_data <= gmii.d;
        end
        data_q <= hold_data;
    end

endmodule

// File: design/eth_crc32_check.sv
// frame check sequence checker, runs crc-32 over each frame with its fcs and flags a bad residue at the end
`timescale 1ns/100ps
`include "gmii_rx_defs.svh"

module eth_crc32_check (
    input  logic                    clk_io,
    input  logic                    rst_n,
    input  gmii_rx_pkg::rx_beat_t   beat_in,
    input  gmii_rx_pkg::rx_status_t status_in,
    output gmii_rx_pkg::rx_beat_t   beat_out,
    output gmii_rx_pkg::rx_status_t status_out
);

    // 0x04C11DB7 in lsb first form
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    logic        crc_bad;

    // output stage
    logic [`GMII_DW-1:0]     data_q;
    logic                    valid_q;
    logic                    last_q;
    gmii_rx_pkg::rx_status_t status_q;

    // one byte of the reflected crc, bit 0 of the byte goes in first
    function automatic logic [31:0] crc_byte(
        input logic [31:0]         crc,
        input logic [`GMII_DW-1:0] data
    );
        logic [31:0] c;
        c = crc ^ {{(32 - `GMII_DW){1'b0}}, data};
        for (int i = 0; i < `GMII_DW; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, beat_in.data);

    // the fcs bytes are part of the sum, a good frame leaves the fixed residue
    assign crc_bad = beat_in.valid & beat_in.last & (crc_next != `FCS_RESIDUE);

    assign beat_out.data  = data_q;
    assign beat_out.valid = valid_q;
    assign beat_out.last  = last_q;
    assign status_out     = status_q;

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            crc_q    <= CRC_INIT;
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            status_q <= '0;
        end else begin
            if (beat_in.valid) begin
                // restart for the next frame after the last byte
                if (beat_in.last) begin
                    crc_q <= CRC_INIT;
                end else begin
                    crc_q <= crc_next;
                end
            end
            valid_q  <= beat_in.valid;
            last_q   <= beat_in.last;
            // framer flags pass through, crc result is merged in here
            status_q         <= status_in;
            status_q.crc_bad <= status_in.valid & crc_bad;
        end
    end

    always_ff @(posedge clk_io) begin
        data_q <= beat_in.data;
    end

endmodule

// File: design/rx_frame_counters.sv
// receive statistics block with an apb slave for counter readout, framer enable and counter clear
`timescale 1ns/100ps
`include "gmii_rx_defs.svh"

module rx_frame_counters (
    input  logic                    clk_io,
    input  logic                    rst_n,
    input  logic [7:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  gmii_rx_pkg::apb_word_t  pwdata,
    output gmii_rx_pkg::apb_word_t  prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  gmii_rx_pkg::rx_beat_t   beat,
    input  gmii_rx_pkg::rx_status_t status,
    output logic                    enable
);

    // per frame byte count, wide enough for jumbo frames
    localparam int FLEN_W = 16;

    logic [FLEN_W-1:0] flen_q;
    logic [FLEN_W-1:0] flen_total;

    gmii_rx_pkg::apb_word_t frames_ok_q;
    gmii_rx_pkg::apb_word_t crc_bad_q;
    gmii_rx_pkg::apb_word_t frame_err_q;
    gmii_rx_pkg::apb_word_t bytes_ok_q;
    logic                   enable_q;

    logic                   apb_wr;
    logic                   addr_hit;
    logic                   clear;
    logic                   frame_good;
    gmii_rx_pkg::apb_word_t rd_word;

    // write lands at the end of the access phase
    assign apb_wr = psel & penable & pwrite;
    assign clear  = apb_wr & (paddr == `REG_CLEAR);

    // status comes with the last beat, which is not yet in flen_q
    assign flen_total = flen_q + 1'b1;
    assign frame_good = status.valid & ~status.crc_bad & ~status.gmii_err & ~status.runt;

    // read mux and address check
    always_comb begin
        addr_hit = 1'b1;
        rd_word  = '0;
        case (paddr)
            `REG_FRAMES_OK: rd_word = frames_ok_q;
            `REG_CRC_BAD:   rd_word = crc_bad_q;
            `REG_FRAME_ERR: rd_word = frame_err_q;
            `REG_BYTES_OK:  rd_word = bytes_ok_q;
            `REG_CTRL:      rd_word = gmii_rx_pkg::apb_word_t'(enable_q);
            // clear reads back as zero
            `REG_CLEAR:     rd_word = '0;
            default:        addr_hit = 1'b0;
        endcase
    end

    // zero wait states, read data straight from the mux
    assign pready  = 1'b1;
    assign prdata  = (psel & ~pwrite) ? rd_word : '0;
    assign pslverr = psel & penable & ~addr_hit;
    assign enable  = enable_q;

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            flen_q      <= '0;
            frames_ok_q <= '0;
            crc_bad_q   <= '0;
            frame_err_q <= '0;
            bytes_ok_q  <= '0;
            enable_q    <= 1'b0;
        end else begin
            // byte count of the frame in flight
            if (beat.valid) begin
                if (beat.last) begin
                    flen_q <= '0;
                end else begin
                    flen_q <= flen_q + 1'b1;
                end
            end

            if (apb_wr && paddr == `REG_CTRL) begin
                enable_q <= pwdata[0];
            end

            // clear beats a frame ending in the same cycle
            if (clear) begin
                frames_ok_q <= '0;
                crc_bad_q   <= '0;
                frame_err_q <= '0;
                bytes_ok_q  <= '0;
            end else if (status.valid) begin
                if (frame_good) begin
                    frames_ok_q <= frames_ok_q + 1'b1;
                    bytes_ok_q  <= bytes_ok_q + gmii_rx_pkg::apb_word_t'(flen_total);
                end
                if (status.crc_bad) begin
                    crc_bad_q <= crc_bad_q + 1'b1;
                end
                // may count together with a crc error
                if (status.gmii_err || status.runt) begin
                    frame_err_q <= frame_err_q + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/gmii_rx_top.sv
// gmii receive front end top, pin capture then framer, fcs check and apb statistics
`timescale 1ns/100ps

module gmii_rx_top (
    input  logic                    clk_io,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_bus_t  gmii_in,
    output gmii_rx_pkg::rx_beat_t   rx_beat,
    output gmii_rx_pkg::rx_status_t rx_status,
    input  logic [7:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  gmii_rx_pkg::apb_word_t  pwdata,
    output gmii_rx_pkg::apb_word_t  prdata,
    output logic                    pready,
    output logic                    pslverr
);

    // d, dv and er captured together
    localparam int GMII_W = $bits(gmii_rx_pkg::gmii_bus_t);

    // forwarded receive clock for everything behind the capture stage
    logic                    rx_clk;
    logic [GMII_W-1:0]       gmii_q;
    gmii_rx_pkg::gmii_bus_t  gmii_cap;
    gmii_rx_pkg::rx_beat_t   fr_beat;
    gmii_rx_pkg::rx_status_t fr_status;
    logic                    enable;

    ssio_sdr_in #(
        .WIDTH (GMII_W)
    ) i_ssio_sdr_in (
        .input_clk  (clk_io),
        .input_d    (gmii_in),
        .output_clk (rx_clk),
        .output_q   (gmii_q),
        .rst_n      (rst_n)
    );

    // flat capture vector back to the bus struct
    assign gmii_cap = gmii_q;

    gmii_rx_framer i_framer (
        .clk_io (rx_clk),
        .rst_n  (rst_n),
        .enable (enable),
        .gmii   (gmii_cap),
        .beat   (fr_beat),
        .status (fr_status)
    );

    eth_crc32_check i_crc_check (
        .clk_io     (rx_clk),
        .rst_n      (rst_n),
        .beat_in    (fr_beat),
        .status_in  (fr_status),
        .beat_out   (rx_beat),
        .status_out (rx_status)
    );

    // statistics watch the checked stream
    rx_frame_counters i_counters (
        .clk_io  (rx_clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .beat    (rx_beat),
        .status  (rx_status),
        .enable  (enable)
    );

endmodule

// File: dv/gmii_rx_tb.sv
// directed testbench for the gmii receive front end that runs as top module gmii_rx_tb with verilog.f
`timescale 1ns/100ps
`include "gmii_rx_defs.svh"

module gmii_rx_tb;

    // frame lengths sent over the whole run with the fcs included
    localparam int FRAME_BYTES = 64 + 64 + 200 + 100 + 80 + 40 + 64;
    // preamble, sfd and the 12 cycle gap around each of the 7 frames
    localparam int FRAME_CYCLES = FRAME_BYTES + 7 * (8 + 12);
    localparam int APB_ACCESSES = 40;
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES + APB_ACCESSES * 200 + 1000;
    // right shift galois taps for a maximal 32 bit sequence
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                    clk_io;
    logic                    rst_n;
    gmii_rx_pkg::gmii_bus_t  gmii_in;
    gmii_rx_pkg::rx_beat_t   rx_beat;
    gmii_rx_pkg::rx_status_t rx_status;
    logic [7:0]              paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    gmii_rx_pkg::apb_word_t  pwdata;
    gmii_rx_pkg::apb_word_t  prdata;
    logic                    pready;
    logic                    pslverr;

    logic [31:0] lfsr_q;
    int          cycle_count;
    int          beat_errors;
    int          status_errors;
    int          reg_errors;

    // beats and status the dut should still deliver
    gmii_rx_pkg::rx_beat_t   exp_beats [$];
    gmii_rx_pkg::rx_status_t exp_status [$];

    // counter values predicted from the frames sent
    gmii_rx_pkg::apb_word_t model_frames_ok;
    gmii_rx_pkg::apb_word_t model_crc_bad;
    gmii_rx_pkg::apb_word_t model_frame_err;
    gmii_rx_pkg::apb_word_t model_bytes_ok;

    gmii_rx_top i_dut (
        .clk_io    (clk_io),
        .rst_n     (rst_n),
        .gmii_in   (gmii_in),
        .rx_beat   (rx_beat),
        .rx_status (rx_status),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk_io = 1'b0;
        forever #2 clk_io = ~clk_io;
    end

    // run limit
    always @(posedge clk_io) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // one lfsr step that returns the bit shifted out
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_bit();
        end
        return b;
    endfunction

    // ieee 802.3 crc with the bits taken lsb first
    // the fcs is the inverted register
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    task automatic compare_beat(input gmii_rx_pkg::rx_beat_t got,
                                input gmii_rx_pkg::rx_beat_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: beat data %h last %b, expected data %h last %b",
                     $time, got.data, got.last, exp.data, exp.last);
            beat_errors++;
        end
    endtask

    task automatic compare_status(input gmii_rx_pkg::rx_status_t got,
                                  input gmii_rx_pkg::rx_status_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: status crc_bad %b gmii_err %b runt %b, expected %b %b %b",
                     $time, got.crc_bad, got.gmii_err, got.runt,
                     exp.crc_bad, exp.gmii_err, exp.runt);
            status_errors++;
        end
    endtask

    task automatic compare_word(input string what, input gmii_rx_pkg::apb_word_t got,
                                input gmii_rx_pkg::apb_word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            reg_errors++;
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            reg_errors++;
        end
    endtask

    // outputs are registered on the rising edge, so they are settled here
    always @(negedge clk_io) begin
        if (rst_n) begin
            if (rx_beat.valid) begin
                if (exp_beats.size() == 0) begin
                    $display("Error at %0t ns: beat %h arrived with none expected",
                             $time, rx_beat.data);
                    beat_errors++;
                end else begin
                    compare_beat(rx_beat, exp_beats.pop_front());
                end
            end
            // status belongs to the cycle of the last beat and no other
            if (rx_status.valid !== (rx_beat.valid & rx_beat.last)) begin
                $display("Error at %0t ns: status valid %b, expected %b from the last beat",
                         $time, rx_status.valid, rx_beat.valid & rx_beat.last);
                status_errors++;
            end
            if (rx_status.valid) begin
                if (exp_status.size() == 0) begin
                    $display("Error at %0t ns: frame status arrived with none expected", $time);
                    status_errors++;
                end else begin
                    compare_status(rx_status, exp_status.pop_front());
                end
            end
        end
    end

    // setup cycle, access cycle, then idle
    task automatic apb_write(input logic [7:0] addr, input gmii_rx_pkg::apb_word_t data);
        @(negedge clk_io);
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk_io);
        penable = 1'b1;
        @(negedge clk_io);
        compare_flag("write pready", pready, 1'b1);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // read data and error are taken while the access cycle is still driven
    task automatic apb_read(input logic [7:0] addr, output gmii_rx_pkg::apb_word_t data,
                            output logic err);
        @(negedge clk_io);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk_io);
        penable = 1'b1;
        @(negedge clk_io);
        data = prdata;
        err = pslverr;
        compare_flag("read pready", pready, 1'b1);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input string what, input logic [7:0] addr,
                             input gmii_rx_pkg::apb_word_t exp);
        gmii_rx_pkg::apb_word_t data;
        logic                   err;
        apb_read(addr, data, err);
        compare_word(what, data, exp);
        compare_flag({what, " pslverr"}, err, 1'b0);
    endtask

    task automatic check_counters();
        check_reg("frames_ok", `REG_FRAMES_OK, model_frames_ok);
        check_reg("crc_bad", `REG_CRC_BAD, model_crc_bad);
        check_reg("frame_err", `REG_FRAME_ERR, model_frame_err);
        check_reg("bytes_ok", `REG_BYTES_OK, model_bytes_ok);
    endtask

    task automatic drive_byte(input logic [7:0] d, input logic er);
        @(negedge clk_io);
        gmii_in.d = d;
        gmii_in.dv = 1'b1;
        gmii_in.er = er;
    endtask

    // len counts payload and fcs
    // er_at is a byte index after the sfd or -1 for none
    task automatic send_frame(input int len, input bit fcs_bad, input int er_at,
                              input bit sfd_bad, input bit expect_rx);
        logic [7:0]              body [$];
        logic [31:0]             crc;
        logic [31:0]             fcs;
        gmii_rx_pkg::rx_beat_t   eb;
        gmii_rx_pkg::rx_status_t es;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len - 4; i++) begin
            body.push_back(rand_byte());
            crc = crc_update(crc, body[i]);
        end
        fcs = ~crc;
        // fcs goes out least significant byte first
        for (int i = 0; i < 4; i++) begin
            body.push_back(fcs[8*i +: 8]);
        end
        if (fcs_bad) begin
            body[len - 3] = body[len - 3] ^ 8'hA5;
        end
        if (expect_rx) begin
            for (int i = 0; i < len; i++) begin
                eb.data = body[i];
                eb.valid = 1'b1;
                eb.last = (i == len - 1);
                exp_beats.push_back(eb);
            end
            es.valid = 1'b1;
            es.crc_bad = fcs_bad;
            es.gmii_err = (er_at >= 0);
            es.runt = (len < `MIN_FRAME_LEN);
            exp_status.push_back(es);
            if (!es.crc_bad && !es.gmii_err && !es.runt) begin
                model_frames_ok = model_frames_ok + 1;
                model_bytes_ok = model_bytes_ok + gmii_rx_pkg::apb_word_t'(len);
            end
            if (es.crc_bad) begin
                model_crc_bad = model_crc_bad + 1;
            end
            if (es.gmii_err || es.runt) begin
                model_frame_err = model_frame_err + 1;
            end
        end
        for (int i = 0; i < 7; i++) begin
            drive_byte(8'h55, 1'b0);
        end
        drive_byte(sfd_bad ? 8'hD4 : 8'hD5, 1'b0);
        for (int i = 0; i < len; i++) begin
            drive_byte(body[i], i == er_at);
        end
        // inter frame gap
        repeat (12) begin
            @(negedge clk_io);
            gmii_in = '0;
        end
    endtask

    // wait for every expected beat and status and then two cycles more for the counters
    task automatic wait_drain();
        while (exp_beats.size() != 0 || exp_status.size() != 0) begin
            @(negedge clk_io);
        end
        repeat (2) @(negedge clk_io);
    endtask

    task automatic test_reset_disabled();
        check_counters();
        check_reg("ctrl", `REG_CTRL, 32'd0);
        check_reg("clear", `REG_CLEAR, 32'd0);
        send_frame(64, 1'b0, -1, 1'b0, 1'b0);
        wait_drain();
        check_counters();
    endtask

    task automatic test_good_frames();
        apb_write(`REG_CTRL, 32'd1);
        check_reg("ctrl", `REG_CTRL, 32'd1);
        send_frame(64, 1'b0, -1, 1'b0, 1'b1);
        send_frame(200, 1'b0, -1, 1'b0, 1'b1);
        wait_drain();
        check_counters();
    endtask

    task automatic test_bad_fcs();
        send_frame(100, 1'b1, -1, 1'b0, 1'b1);
        wait_drain();
        check_counters();
    endtask

    task automatic test_error_frames();
        send_frame(80, 1'b0, 30, 1'b0, 1'b1);
        send_frame(40, 1'b0, -1, 1'b0, 1'b1);
        wait_drain();
        check_counters();
    endtask

    task automatic test_bad_sfd();
        send_frame(64, 1'b0, -1, 1'b1, 1'b0);
        wait_drain();
        check_counters();
    endtask

    task automatic test_clear();
        gmii_rx_pkg::apb_word_t data;
        logic                   err;
        apb_write(`REG_CLEAR, 32'hFFFF_FFFF);
        model_frames_ok = '0;
        model_crc_bad = '0;
        model_frame_err = '0;
        model_bytes_ok = '0;
        check_counters();
        // 0x20 is past the register map
        apb_read(8'h20, data, err);
        compare_word("unmapped offset", data, 32'd0);
        compare_flag("unmapped pslverr", err, 1'b1);
    endtask

    initial begin
        rst_n = 1'b0;
        gmii_in = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        lfsr_q = 32'h305f_f79e;
        cycle_count = 0;
        beat_errors = 0;
        status_errors = 0;
        reg_errors = 0;
        model_frames_ok = '0;
        model_crc_bad = '0;
        model_frame_err = '0;
        model_bytes_ok = '0;
        repeat (8) @(negedge clk_io);
        rst_n = 1'b1;
        @(negedge clk_io);

        test_reset_disabled();
        test_good_frames();
        test_bad_fcs();
        test_error_frames();
        test_bad_sfd();
        test_clear();

        $display("errors: beat %0d, status %0d, register %0d",
                 beat_errors, status_errors, reg_errors);
        if (beat_errors + status_errors + reg_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
design/gmii_rx_pkg.sv
design/ssio_sdr_in.sv
design/gmii_rx_framer.sv
design/eth_crc32_check.sv
design/rx_frame_counters.sv
design/gmii_rx_top.sv
dv/gmii_rx_tb.sv

// File: run.sh
#!/bin/sh
# build and run the gmii receive testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module gmii_rx_tb -o gmii_rx_sim \
    && ./obj_dir/gmii_rx_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
